// File: common/cl_cfg_pkg.sv
`default_nettype none

package cl_cfg_pkg;

   //--------------------------------------------------
   // Channel counts
   //--------------------------------------------------

   // Statistics ports exist only on controllers A, B and D
   localparam int NUM_STAT_CH = 3;

   // Scrub channels A, B, C and D
   localparam int NUM_SCRB_CH = 4;

   //--------------------------------------------------
   // Pipeline depths
   //--------------------------------------------------

   // Register stages between shell and DDR controller stat ports
   localparam int STAT_PIPE_STAGES = 8;

   // Cycles from global reset release to block reset release
   localparam int RST_PIPE_STAGES = 4;

   //--------------------------------------------------
   // Control word layout
   //--------------------------------------------------

   localparam int CTL_DBG_EN_BIT  = 31;
   // Low bit of the 3-bit debug memory select, bits 30:28
   localparam int CTL_DBG_SEL_LSB = 28;

   // Scrub enables with C and D swapped in the word
   localparam int CTL_SCRB_A_BIT = 0;
   localparam int CTL_SCRB_B_BIT = 1;
   localparam int CTL_SCRB_D_BIT = 2;
   localparam int CTL_SCRB_C_BIT = 3;

   // Fixed PCI ID words
   localparam logic [31:0] CL_ID0 = 32'hF000_1D0F;
   localparam logic [31:0] CL_ID1 = 32'h1D51_FEDD;

endpackage

`default_nettype wire

// File: common/cl_types_pkg.sv
`default_nettype none

package cl_types_pkg;

   //--------------------------------------------------
   // Statistics port channels
   //--------------------------------------------------

   // Shell to controller request, 42 bits
   typedef struct packed {
      logic        wr;
      logic        rd;
      logic [7:0]  addr;
      logic [31:0] wdata;
   } stat_req_t;

   // Controller to shell acknowledge, 41 bits
   typedef struct packed {
      logic        ack;
      logic [7:0]  irq;
      logic [31:0] rdata;
   } stat_ack_t;

   //--------------------------------------------------
   // Scrub status
   //--------------------------------------------------

   // Current scrub address of one DDR channel
   typedef logic [63:0] scrub_addr_t;

   // Index of each channel in the scrub arrays
   localparam int SCRB_CH_A = 0;
   localparam int SCRB_CH_B = 1;
   localparam int SCRB_CH_C = 2;
   localparam int SCRB_CH_D = 3;

   // Debug memory select where codes 4 to 7 fall back to A
   typedef enum logic [2:0] {
      DBG_DDRA = 3'd0,
      DBG_DDRB = 3'd1,
      DBG_DDRD = 3'd2,
      DBG_DDRC = 3'd3
   } dbg_sel_e;

endpackage

`default_nettype wire

// File: hdl/cl_dram_glue_top.sv
`timescale 1ns/100ps
`default_nettype none

module cl_dram_glue_top
   import cl_cfg_pkg::*;
   import cl_types_pkg::*;
(
   input  logic                   clk,
   input  logic                   sync_rst_n,

   // Shell control and status
   input  logic [31:0]            ctl_word,
   input  logic                   flr_assert,
   output logic                   flr_done,
   input  scrub_addr_t            scrub_addr [NUM_SCRB_CH],
   output logic [NUM_SCRB_CH-1:0] scrub_en,
   output logic [31:0]            id0,
   output logic [31:0]            id1,

   // Statistics, shell side
   input  stat_req_t              stat_req_in  [NUM_STAT_CH],
   output stat_ack_t              stat_ack_out [NUM_STAT_CH],

   // Statistics, controller side
   output stat_req_t              stat_req_out [NUM_STAT_CH],
   input  stat_ack_t              stat_ack_in  [NUM_STAT_CH]
);

   logic ctl_rst_n;
   logic stat_rst_n;

   //--------------------------------------------------
   // Block resets
   //--------------------------------------------------

   reset_tree reset_tree_inst (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .ctl_rst_n  (ctl_rst_n),
      .stat_rst_n (stat_rst_n)
   );

   //--------------------------------------------------
   // Control, ID readback and FLR
   //--------------------------------------------------

   ctl_status_regs ctl_status_regs_inst (
      .clk        (clk),
      .ctl_rst_n  (ctl_rst_n),
      .ctl_word   (ctl_word),
      .flr_assert (flr_assert),
      .scrub_addr (scrub_addr),
      .scrub_en   (scrub_en),
      .id0        (id0),
      .id1        (id1),
      .flr_done   (flr_done)
   );

   // DDR statistics bridge
   stat_bridge #(
      .STAGES (STAT_PIPE_STAGES)
   ) stat_bridge_inst (
      .clk          (clk),
      .stat_rst_n   (stat_rst_n),
      .stat_req_in  (stat_req_in),
      .stat_req_out (stat_req_out),
      .stat_ack_in  (stat_ack_in),
      .stat_ack_out (stat_ack_out)
   );

endmodule

`default_nettype wire

// File: hdl/ctl_status_regs.sv
`timescale 1ns/100ps
`default_nettype none

module ctl_status_regs
   import cl_cfg_pkg::*;
   import cl_types_pkg::*;
(
   input  logic                   clk,
   input  logic                   ctl_rst_n,
   input  logic [31:0]            ctl_word,
   input  logic                   flr_assert,
   input  scrub_addr_t            scrub_addr [NUM_SCRB_CH],
   output logic [NUM_SCRB_CH-1:0] scrub_en,
   output logic [31:0]            id0,
   output logic [31:0]            id1,
   output logic                   flr_done
);

   logic [31:0] ctl_q;
   logic        dbg_en;
   dbg_sel_e    dbg_sel;
   scrub_addr_t dbg_addr;
   logic        flr_assert_q;

   //--------------------------------------------------
   // Control word capture
   //--------------------------------------------------

   always_ff @(posedge clk or negedge ctl_rst_n)
   begin
      if (!ctl_rst_n)
         ctl_q <= '0;
      else
         ctl_q <= ctl_word;
   end

   // Word bits 2 and 3 map to channels D and C
   assign scrub_en[SCRB_CH_A] = ctl_q[CTL_SCRB_A_BIT];
   assign scrub_en[SCRB_CH_B] = ctl_q[CTL_SCRB_B_BIT];
   assign scrub_en[SCRB_CH_C] = ctl_q[CTL_SCRB_C_BIT];
   assign scrub_en[SCRB_CH_D] = ctl_q[CTL_SCRB_D_BIT];

   assign dbg_en  = ctl_q[CTL_DBG_EN_BIT];
   assign dbg_sel = dbg_sel_e'(ctl_q[CTL_DBG_SEL_LSB +: $bits(dbg_sel_e)]);

   //--------------------------------------------------
   // ID readback
   //--------------------------------------------------

   always_comb
   begin
      case (dbg_sel)
         DBG_DDRA: dbg_addr = scrub_addr[SCRB_CH_A];
         DBG_DDRB: dbg_addr = scrub_addr[SCRB_CH_B];
         DBG_DDRD: dbg_addr = scrub_addr[SCRB_CH_D];
         DBG_DDRC: dbg_addr = scrub_addr[SCRB_CH_C];
         // Unused codes 4 to 7
         default:  dbg_addr = scrub_addr[SCRB_CH_A];
      endcase
   end

   // Live scrub address while debugging, PCI IDs otherwise
   always_ff @(posedge clk or negedge ctl_rst_n)
   begin
      if (!ctl_rst_n)
      begin
         id0 <= CL_ID0;
         id1 <= CL_ID1;
      end
      else if (dbg_en)
      begin
         id0 <= dbg_addr[31:0];
         id1 <= dbg_addr[63:32];
      end
      else
      begin
         id0 <= CL_ID0;
         id1 <= CL_ID1;
      end
   end

   //--------------------------------------------------
   // FLR responder
   //--------------------------------------------------

   // Done pulses every other cycle while the request is held
   always_ff @(posedge clk or negedge ctl_rst_n)
   begin
      if (!ctl_rst_n)
      begin
         flr_assert_q <= 1'b0;
         flr_done     <= 1'b0;
      end
      else
      begin
         flr_assert_q <= flr_assert;
         flr_done     <= flr_assert_q && !flr_done;
      end
   end

   a_flr_done_pulse : assert property (
      @(posedge clk) disable iff (!ctl_rst_n) flr_done |=> !flr_done
   );

endmodule

`default_nettype wire

// File: hdl/delay_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module delay_pipe #(
   parameter int WIDTH  = 1,
   parameter int STAGES = 1
) (
   input  logic             clk,
   input  logic             sync_rst_n,
   input  logic [WIDTH-1:0] in_bus,
   output logic [WIDTH-1:0] out_bus
);

   // Stage 0 takes the input, the last stage drives the output
   logic [WIDTH-1:0] pipe_q [STAGES];

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         for (int i = 0; i < STAGES; i++)
         begin
            pipe_q[i] <= '0;
         end
      end
      else
      begin
         pipe_q[0] <= in_bus;
         for (int i = 1; i < STAGES; i++)
         begin
            pipe_q[i] <= pipe_q[i-1];
         end
      end
   end

   assign out_bus = pipe_q[STAGES-1];

endmodule

`default_nettype wire

// File: hdl/reset_tree.sv
`timescale 1ns/100ps
`default_nettype none

module reset_tree
   import cl_cfg_pkg::*;
(
   input  logic clk,
   input  logic sync_rst_n,
   output logic ctl_rst_n,
   output logic stat_rst_n
);

   //--------------------------------------------------
   // Per-block reset release
   //--------------------------------------------------

   // A constant 1 walks through each pipe once the global reset lifts.
   // The pipe registers clear at once on the falling edge of sync_rst_n,
   // so each block reset asserts asynchronously and releases late
   delay_pipe #(
      .WIDTH  (1),
      .STAGES (RST_PIPE_STAGES)
   ) ctl_rst_pipe_inst (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .in_bus     (1'b1),
      .out_bus    (ctl_rst_n)
   );

   // Separate copy for the stat bridge keeps its reset fanout local
   delay_pipe #(
      .WIDTH  (1),
      .STAGES (RST_PIPE_STAGES)
   ) stat_rst_pipe_inst (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .in_bus     (1'b1),
      .out_bus    (stat_rst_n)
   );

   //--------------------------------------------------
   // Assertions
   //--------------------------------------------------

   // No block may come out of reset while the global reset is held
   a_rst_held : assert property (
      @(posedge clk) !sync_rst_n |-> (!ctl_rst_n && !stat_rst_n)
   );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the DRAM glue testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f verilog.f \
   --top-module tb_cl_dram_glue -o tb_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
   cat "$BUILD_LOG"
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "TEST RESULT: FAIL" "$SIM_LOG"; then
   exit 1
fi
exit 0

// File: stat/stat_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module stat_bridge
   import cl_cfg_pkg::*;
   import cl_types_pkg::*;
#(
   parameter int STAGES = STAT_PIPE_STAGES
) (
   input  logic      clk,
   input  logic      stat_rst_n,
   input  stat_req_t stat_req_in  [NUM_STAT_CH],
   output stat_req_t stat_req_out [NUM_STAT_CH],
   input  stat_ack_t stat_ack_in  [NUM_STAT_CH],
   output stat_ack_t stat_ack_out [NUM_STAT_CH]
);

   //--------------------------------------------------
   // Per-channel pipelines
   //--------------------------------------------------

   // Plain register stages for timing, no flow control.
   // Reset clears the strobes in flight along with the payload
   for (genvar ch = 0; ch < NUM_STAT_CH; ch++)
   begin : g_ch

      // Shell to controller
      delay_pipe #(
         .WIDTH  ($bits(stat_req_t)),
         .STAGES (STAGES)
      ) req_pipe_inst (
         .clk        (clk),
         .sync_rst_n (stat_rst_n),
         .in_bus     (stat_req_in[ch]),
         .out_bus    (stat_req_out[ch])
      );

      // Controller back to shell
      delay_pipe #(
         .WIDTH  ($bits(stat_ack_t)),
         .STAGES (STAGES)
      ) ack_pipe_inst (
         .clk        (clk),
         .sync_rst_n (stat_rst_n),
         .in_bus     (stat_ack_in[ch]),
         .out_bus    (stat_ack_out[ch])
      );

      // The shell never issues a read and a write in one request
      a_req_onehot : assert property (
         @(posedge clk) disable iff (!stat_rst_n)
            !(stat_req_in[ch].wr && stat_req_in[ch].rd)
      );

   end

endmodule

`default_nettype wire

// File: verification/cl_glue_cases.txt
# kind ctl_word arg exp_scrub_en exp_id0 exp_id1 (hex except kind and arg)
# kind 1 control, 2 FLR held arg cycles, 3 random stat traffic arg cycles, 4 reset
1 00000000 0 0 F0001D0F 1D51FEDD
1 00000001 0 1 F0001D0F 1D51FEDD
1 00000002 0 2 F0001D0F 1D51FEDD
1 00000004 0 8 F0001D0F 1D51FEDD
1 00000008 0 4 F0001D0F 1D51FEDD
1 00000006 0 A F0001D0F 1D51FEDD
1 80000000 0 0 0000A0A0 1111AAAA
1 90000001 0 1 0000B0B0 2222BBBB
1 A0000004 0 8 0000D0D0 4444DDDD
1 B0000008 0 4 0000C0C0 3333CCCC
1 C0000002 0 2 0000A0A0 1111AAAA
1 D000000F 0 F 0000A0A0 1111AAAA
1 E0000000 0 0 0000A0A0 1111AAAA
1 F0000005 0 9 0000A0A0 1111AAAA
1 70000003 0 3 F0001D0F 1D51FEDD
2 00000000 1 0 00000000 00000000
2 00000000 6 0 00000000 00000000
3 00000000 150 0 00000000 00000000
4 00000000 0 0 00000000 00000000
3 00000000 60 0 00000000 00000000
1 B0000008 0 4 0000C0C0 3333CCCC

// File: verification/cl_glue_checker.sv
`timescale 1ns/100ps
`default_nettype none

module cl_glue_checker
   import cl_cfg_pkg::*;
   import cl_types_pkg::*;
(
   input  logic                   clk,
   input  logic                   sync_rst_n,
   input  logic                   flr_assert,
   input  logic                   flr_done,
   input  logic [NUM_SCRB_CH-1:0] scrub_en,
   input  logic [31:0]            id0,
   input  logic [31:0]            id1,
   input  stat_req_t              stat_req_in  [NUM_STAT_CH],
   input  stat_req_t              stat_req_out [NUM_STAT_CH],
   input  stat_ack_t              stat_ack_in  [NUM_STAT_CH],
   input  stat_ack_t              stat_ack_out [NUM_STAT_CH],
   output int                     reg_errs,
   output int                     flr_errs,
   output int                     stat_errs
);

   // Expected items per channel and direction with one per pipeline stage
   stat_req_t req_q [NUM_STAT_CH][$];
   stat_ack_t ack_q [NUM_STAT_CH][$];
   stat_req_t exp_req;
   stat_ack_t exp_ack;
   int        rel_cnt;
   // Lengths of the flr_assert runs that ended one and two edges back
   int        run_d1;
   int        run_d2;

   //--------------------------------------------------
   // FLR and statistics checks on every cycle
   //--------------------------------------------------

   // Sampled on the rising edge, before the DUT registers update
   always @(posedge clk)
   begin
      if (!sync_rst_n || rel_cnt < RST_PIPE_STAGES)
      begin
         // Block resets still low, so every pipeline stage reads zero
         rel_cnt = sync_rst_n ? rel_cnt + 1 : 0;
         run_d1  = 0;
         run_d2  = 0;
         for (int ch = 0; ch < NUM_STAT_CH; ch++)
         begin
            req_q[ch].delete();
            ack_q[ch].delete();
            for (int i = 0; i < STAT_PIPE_STAGES; i++)
            begin
               req_q[ch].push_back('0);
               ack_q[ch].push_back('0);
            end
         end
      end
      else
      begin
         // Done is high when the request run seen two edges back has odd length
         if (flr_done !== run_d2[0])
         begin
            $display("[FAIL] flr_done expected %0b actual %0b", run_d2[0], flr_done);
            flr_errs++;
         end
         run_d2 = run_d1;
         run_d1 = flr_assert ? run_d1 + 1 : 0;
         for (int ch = 0; ch < NUM_STAT_CH; ch++)
         begin
            exp_req = req_q[ch].pop_front();
            exp_ack = ack_q[ch].pop_front();
            if (stat_req_out[ch] !== exp_req)
            begin
               $display("[FAIL] stat_req ch%0d expected %h actual %h",
                        ch, exp_req, stat_req_out[ch]);
               stat_errs++;
            end
            if (stat_ack_out[ch] !== exp_ack)
            begin
               $display("[FAIL] stat_ack ch%0d expected %h actual %h",
                        ch, exp_ack, stat_ack_out[ch]);
               stat_errs++;
            end
            req_q[ch].push_back(stat_req_in[ch]);
            ack_q[ch].push_back(stat_ack_in[ch]);
         end
      end
   end

   //--------------------------------------------------
   // Register checks called from the testbench
   //--------------------------------------------------

   task automatic check_word(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
      if (act !== exp)
      begin
         $display("[FAIL] %s expected %h actual %h", name, exp, act);
         reg_errs++;
      end
   endtask

   task automatic check_reset_state(input string name);
      check_word({name, " id0"}, CL_ID0, id0);
      check_word({name, " id1"}, CL_ID1, id1);
      check_word({name, " scrub_en"}, 32'h0, 32'(scrub_en));
      check_word({name, " flr_done"}, 32'h0, 32'(flr_done));
      for (int ch = 0; ch < NUM_STAT_CH; ch++)
      begin
         check_word($sformatf("%s stat strobes ch%0d", name, ch), 32'h0,
                    32'({stat_req_out[ch].wr, stat_req_out[ch].rd, stat_ack_out[ch].ack}));
      end
   endtask

   task automatic check_scrub_en(input string name, input logic [NUM_SCRB_CH-1:0] exp);
      check_word({name, " scrub_en"}, 32'(exp), 32'(scrub_en));
   endtask

   task automatic check_ids(input string name, input logic [31:0] exp0,
                            input logic [31:0] exp1);
      check_word({name, " id0"}, exp0, id0);
      check_word({name, " id1"}, exp1, id1);
   endtask

endmodule

`default_nettype wire

// File: verification/tb_cl_dram_glue.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cl_dram_glue
   import cl_cfg_pkg::*;
   import cl_types_pkg::*;
();

   localparam string CASES_FILE  = "verification/cl_glue_cases.txt";
   localparam int    FLR_TIMEOUT = 8;

   logic                   clk;
   logic                   sync_rst_n;
   logic [31:0]            ctl_word;
   logic                   flr_assert;
   logic                   flr_done;
   scrub_addr_t            scrub_addr [NUM_SCRB_CH];
   logic [NUM_SCRB_CH-1:0] scrub_en;
   logic [31:0]            id0;
   logic [31:0]            id1;
   stat_req_t              stat_req_in  [NUM_STAT_CH];
   stat_req_t              stat_req_out [NUM_STAT_CH];
   stat_ack_t              stat_ack_in  [NUM_STAT_CH];
   stat_ack_t              stat_ack_out [NUM_STAT_CH];
   int                     reg_errs;
   int                     flr_errs;
   int                     stat_errs;
   int                     other_errs;
   int                     seed;

   // Case file record fields
   int                     fd;
   string                  line;
   int                     kind;
   int                     arg;
   int                     n_cases;
   logic [31:0]            word;
   logic [NUM_SCRB_CH-1:0] exp_en;
   logic [31:0]            exp_id0;
   logic [31:0]            exp_id1;

   initial clk = 1'b0;
   always #2 clk = ~clk;

   cl_dram_glue_top cl_dram_glue_top_inst (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .ctl_word     (ctl_word),
      .flr_assert   (flr_assert),
      .flr_done     (flr_done),
      .scrub_addr   (scrub_addr),
      .scrub_en     (scrub_en),
      .id0          (id0),
      .id1          (id1),
      .stat_req_in  (stat_req_in),
      .stat_ack_out (stat_ack_out),
      .stat_req_out (stat_req_out),
      .stat_ack_in  (stat_ack_in)
   );

   cl_glue_checker cl_glue_checker_inst (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .flr_assert   (flr_assert),
      .flr_done     (flr_done),
      .scrub_en     (scrub_en),
      .id0          (id0),
      .id1          (id1),
      .stat_req_in  (stat_req_in),
      .stat_req_out (stat_req_out),
      .stat_ack_in  (stat_ack_in),
      .stat_ack_out (stat_ack_out),
      .reg_errs     (reg_errs),
      .flr_errs     (flr_errs),
      .stat_errs    (stat_errs)
   );

   //--------------------------------------------------
   // Stimulus tasks that start and end on a falling edge
   //--------------------------------------------------

   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++)
         @(negedge clk);
   endtask

   task automatic quiet_stat();
      for (int ch = 0; ch < NUM_STAT_CH; ch++)
      begin
         stat_req_in[ch] = '0;
         stat_ack_in[ch] = '0;
      end
   endtask

   // Never a read and a write in one request
   task automatic drive_random_stat();
      logic [31:0] r;
      for (int ch = 0; ch < NUM_STAT_CH; ch++)
      begin
         r = $random(seed);
         stat_req_in[ch].wr    = (r[1:0] == 2'd1);
         stat_req_in[ch].rd    = (r[1:0] == 2'd2);
         stat_req_in[ch].addr  = r[15:8];
         stat_req_in[ch].wdata = $random(seed);
         r = $random(seed);
         stat_ack_in[ch].ack   = r[0];
         stat_ack_in[ch].irq   = r[15:8];
         stat_ack_in[ch].rdata = $random(seed);
      end
   endtask

   task automatic reset_dut(input string name);
      sync_rst_n = 1'b0;
      ctl_word   = '0;
      flr_assert = 1'b0;
      quiet_stat();
      idle_cycles(5);
      cl_glue_checker_inst.check_reset_state({name, " held"});
      sync_rst_n = 1'b1;
      // Block resets release RST_PIPE_STAGES edges later
      idle_cycles(RST_PIPE_STAGES + 2);
      cl_glue_checker_inst.check_reset_state({name, " released"});
   endtask

   // Reset strikes with the debug readback on and stat items in flight
   task automatic run_reset_case(input int idx);
      ctl_word = 32'hB000_000F;
      for (int i = 0; i < STAT_PIPE_STAGES; i++)
      begin
         drive_random_stat();
         @(negedge clk);
      end
      reset_dut($sformatf("case %0d reset", idx));
   endtask

   task automatic run_ctl_case(input int idx);
      string name;
      name     = $sformatf("case %0d ctl %h", idx, word);
      ctl_word = word;
      @(negedge clk);
      cl_glue_checker_inst.check_scrub_en(name, exp_en);
      idle_cycles(2);
      cl_glue_checker_inst.check_ids(name, exp_id0, exp_id1);
   endtask

   task automatic run_flr_case(input int idx, input int n);
      int   held;
      int   low_cnt;
      int   waited;
      logic seen;
      held       = 0;
      seen       = 1'b0;
      flr_assert = 1'b1;
      // Request held for exactly n cycles
      while (held < n)
      begin
         @(negedge clk);
         held++;
         if (flr_done === 1'b1)
            seen = 1'b1;
      end
      flr_assert = 1'b0;
      waited     = 0;
      // A short request still gets its done pulse two cycles after the rise
      while (!seen && waited < FLR_TIMEOUT)
      begin
         @(negedge clk);
         waited++;
         if (flr_done === 1'b1)
            seen = 1'b1;
      end
      if (!seen)
      begin
         $display("Timeout: flr_done never rose in case %0d", idx);
         other_errs++;
      end
      low_cnt = 0;
      waited  = 0;
      while (low_cnt < 2 && waited < FLR_TIMEOUT)
      begin
         @(negedge clk);
         waited++;
         low_cnt = (flr_done === 1'b0) ? low_cnt + 1 : 0;
      end
      if (low_cnt < 2)
      begin
         $display("Timeout: flr_done did not settle low in case %0d", idx);
         other_errs++;
      end
   endtask

   task automatic run_stat_case(input int n);
      for (int i = 0; i < n; i++)
      begin
         drive_random_stat();
         @(negedge clk);
      end
      quiet_stat();
      // Let the last items drain out of the pipelines
      idle_cycles(STAT_PIPE_STAGES + 2);
   endtask

   //--------------------------------------------------
   // Main sequence
   //--------------------------------------------------

   initial
   begin
      seed       = 32'hd640c58a;
      other_errs = 0;
      n_cases    = 0;
      sync_rst_n = 1'b0;
      ctl_word   = '0;
      flr_assert = 1'b0;
      scrub_addr[SCRB_CH_A] = 64'h1111_AAAA_0000_A0A0;
      scrub_addr[SCRB_CH_B] = 64'h2222_BBBB_0000_B0B0;
      scrub_addr[SCRB_CH_C] = 64'h3333_CCCC_0000_C0C0;
      scrub_addr[SCRB_CH_D] = 64'h4444_DDDD_0000_D0D0;
      quiet_stat();
      @(negedge clk);
      reset_dut("power-on reset");

      fd = $fopen(CASES_FILE, "r");
      if (fd == 0)
      begin
         $display("Could not open the cases file %s", CASES_FILE);
         other_errs++;
      end
      else
      begin
         while (!$feof(fd))
         begin
            line = "";
            void'($fgets(line, fd));
            // Comment and blank lines do not scan as six fields
            if ($sscanf(line, "%d %h %d %h %h %h",
                        kind, word, arg, exp_en, exp_id0, exp_id1) == 6)
            begin
               n_cases++;
               case (kind)
                  1: run_ctl_case(n_cases);
                  2: run_flr_case(n_cases, arg);
                  3: run_stat_case(arg);
                  4: run_reset_case(n_cases);
                  default:
                  begin
                     $display("Unknown record kind %0d in the cases file", kind);
                     other_errs++;
                  end
               endcase
            end
         end
         $fclose(fd);
      end
      if (n_cases == 0)
      begin
         $display("No cases were read from %s", CASES_FILE);
         other_errs++;
      end

      $display("Errors: registers=%0d flr=%0d stat=%0d other=%0d cases=%0d",
               reg_errs, flr_errs, stat_errs, other_errs, n_cases);
      if (reg_errs + flr_errs + stat_errs + other_errs == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
common/cl_cfg_pkg.sv
common/cl_types_pkg.sv
hdl/delay_pipe.sv
hdl/reset_tree.sv
hdl/ctl_status_regs.sv
stat/stat_bridge.sv
hdl/cl_dram_glue_top.sv
verification/cl_glue_checker.sv
verification/tb_cl_dram_glue.sv
